// File: common/rp_pkg.sv
// Analog path shared definitions
`default_nettype none

package rp_pkg;

  //////////////////////////////
  // Widths and constants
  //////////////////////////////

  localparam int unsigned ADC_DW  = 16;   // ADC sample width
  localparam int unsigned DAC_DW  = 14;   // DAC converter width
  localparam int unsigned SYS_AW  = 20;   // System bus address
  localparam int unsigned SYS_DW  = 32;   // System bus data
  localparam int unsigned PDM_DW  = 8;    // PDM duty setting
  localparam int unsigned PDM_RNG = 256;  // PDM period in cycles

  //////////////////////////////
  // Sample types
  //////////////////////////////

  // Acquisition side
  typedef logic signed [ADC_DW-1:0] adc_sample_t;  // Two's complement sample
  typedef logic        [ADC_DW-1:0] adc_raw_t;     // Raw word, negative slope

  // Generation side
  typedef logic signed [DAC_DW-1:0] dac_sample_t;  // Two's complement sample
  typedef logic signed [DAC_DW:0]   dac_sum_t;     // One guard bit for overflow
  typedef logic        [DAC_DW-1:0] dac_code_t;    // Pin code, negative slope

  typedef logic        [PDM_DW-1:0] pdm_cfg_t;     // Pulse density setting

  //////////////////////////////
  // System bus
  //////////////////////////////

  typedef logic [SYS_AW-1:0] sys_addr_t;
  typedef logic [SYS_DW-1:0] sys_data_t;

  // Request, strobes last one cycle
  typedef struct packed {
    sys_addr_t addr;   // Byte address
    sys_data_t wdata;  // Write data
    logic      wen;    // Write strobe
    logic      ren;    // Read strobe
  } sys_req_t;

  // Response, one cycle after the strobe
  typedef struct packed {
    sys_data_t rdata;  // Read data
    logic      ack;    // Transfer done
    logic      err;    // Unmapped address
  } sys_rsp_t;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam sys_addr_t REG_LOOP = 20'h00000;  // Bit 0 digital loopback
  localparam sys_addr_t REG_LED  = 20'h00004;  // LED value, low byte
  localparam sys_addr_t REG_PDM0 = 20'h00010;  // First PDM setting

  // Remaining PDM settings follow REG_PDM0 at word spacing

endpackage

`default_nettype wire

// File: analog/adc_frontend.sv
// ADC front end
`timescale 1ns/1ps
`default_nettype none

module adc_frontend #(
  parameter int unsigned NUM_CH = 2                      // Number of ADC channels
)(
  input  logic                                adc_clk,     // ADC clock
  input  logic                                rst_n_i,     // Sync reset, active low
  input  rp_pkg::adc_raw_t    [NUM_CH-1:0]    adc_dat_i,   // Raw converter words
  input  logic                                loop_en_i,   // Digital loopback enable
  input  rp_pkg::dac_sample_t [NUM_CH-1:0]    dac_loop_i,  // Saturated DAC samples
  output rp_pkg::adc_sample_t [NUM_CH-1:0]    adc_dat_o    // Converted samples
);

  import rp_pkg::*;

  // Midscale raw code, converts to a zero sample
  localparam adc_raw_t RAW_ZERO = {1'b0, {(ADC_DW-1){1'b1}}};

  adc_raw_t    [NUM_CH-1:0] adc_raw_q;   // Input register
  adc_sample_t [NUM_CH-1:0] adc_conv;    // Two's complement
  adc_sample_t [NUM_CH-1:0] adc_loop;    // Loopback, zero extended

  //////////////////////////////
  // Input register
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      adc_raw_q <= {NUM_CH{RAW_ZERO}};
    else
      adc_raw_q <= adc_dat_i;              // One cycle latency
  end

  //////////////////////////////
  // Conversion and loopback
  //////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      // Sign kept, magnitude bits inverted
      adc_conv[ch] = {adc_raw_q[ch][ADC_DW-1], ~adc_raw_q[ch][ADC_DW-2:0]};
      // DAC sample with zeros on top
      adc_loop[ch] = {{(ADC_DW-DAC_DW){1'b0}}, dac_loop_i[ch]};
      adc_dat_o[ch] = loop_en_i ? adc_loop[ch] : adc_conv[ch];  // Loopback bypasses register
    end
  end

endmodule

`default_nettype wire

// File: analog/dac_backend.sv
// DAC back end
`timescale 1ns/1ps
`default_nettype none

module dac_backend #(
  parameter int unsigned NUM_CH = 2                      // Number of DAC channels
)(
  input  logic                                adc_clk,     // ADC clock
  input  logic                                rst_n_i,     // Sync reset, active low
  input  rp_pkg::dac_sample_t [NUM_CH-1:0]    asg_dat_i,   // Generator samples
  input  rp_pkg::dac_sample_t [NUM_CH-1:0]    pid_dat_i,   // Controller samples
  output rp_pkg::dac_sample_t [NUM_CH-1:0]    dac_sat_o,   // Saturated sum for loopback
  output rp_pkg::dac_code_t   [NUM_CH-1:0]    dac_dat_o,   // Registered pin code
  output logic                                dac_rst_o    // DAC reset, active high
);

  import rp_pkg::*;

  dac_sum_t    [NUM_CH-1:0] dac_sum;     // Full range sum
  dac_sample_t [NUM_CH-1:0] dac_sat;     // Clipped to DAC range
  dac_code_t   [NUM_CH-1:0] dac_code;    // Negative slope code
  dac_code_t   [NUM_CH-1:0] dac_dat_q;
  logic                     dac_rst_q;

  //////////////////////////////
  // Sum and saturation
  //////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      // Sign extended to the guard bit
      dac_sum[ch] = dac_sum_t'($signed(asg_dat_i[ch])) + dac_sum_t'($signed(pid_dat_i[ch]));

      if (dac_sum[ch][DAC_DW] != dac_sum[ch][DAC_DW-1])  // Top bits differ
        dac_sat[ch] = {dac_sum[ch][DAC_DW], {(DAC_DW-1){~dac_sum[ch][DAC_DW]}}};
      else
        dac_sat[ch] = dac_sum[ch][DAC_DW-1:0];            // In range

      // Sign kept, lower bits inverted
      dac_code[ch] = {dac_sat[ch][DAC_DW-1], ~dac_sat[ch][DAC_DW-2:0]};
    end
  end

  assign dac_sat_o = dac_sat;

  //////////////////////////////
  // DAC reset and output
  //////////////////////////////

  // Held one cycle past the release of rst_n_i
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      dac_rst_q <= 1'b1;
    else
      dac_rst_q <= 1'b0;
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i || dac_rst_q)
      dac_dat_q <= '0;                    // Pins quiet during DAC reset
    else
      dac_dat_q <= dac_code;
  end

  assign dac_dat_o = dac_dat_q;
  assign dac_rst_o = dac_rst_q;

endmodule

`default_nettype wire

// File: logic/pdm_gen.sv
// First-order PDM modulators
`timescale 1ns/1ps
`default_nettype none

module pdm_gen #(
  parameter int unsigned NUM_PDM = 4                     // Number of PDM outputs
)(
  input  logic                               adc_clk,  // ADC clock
  input  logic                               rst_n_i,  // Sync reset, active low
  input  rp_pkg::pdm_cfg_t [NUM_PDM-1:0]     cfg_i,    // Duty settings
  output logic             [NUM_PDM-1:0]     pdm_o     // Pulse density outputs
);

  import rp_pkg::*;

  // Accumulator wraps once per period
  localparam int unsigned ACC_W = $clog2(PDM_RNG);

  logic [NUM_PDM-1:0] [ACC_W-1:0] acc_q;     // Phase accumulators
  logic [NUM_PDM-1:0] [ACC_W:0]   acc_sum;   // Carry in the top bit
  logic [NUM_PDM-1:0]             pdm_q;     // Registered carry

  //////////////////////////////
  // Accumulate
  //////////////////////////////

  always_comb
  begin
    for (int i = 0; i < NUM_PDM; i++)
    begin
      acc_sum[i] = {1'b0, acc_q[i]} + (ACC_W+1)'(cfg_i[i]);
    end
  end

  //////////////////////////////
  // State and output
  //////////////////////////////

  // Carry count per period equals the setting
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      acc_q <= '0;
      pdm_q <= '0;                          // Outputs low after reset
    end
    else
    begin
      for (int i = 0; i < NUM_PDM; i++)
      begin
        acc_q[i] <= acc_sum[i][ACC_W-1:0];  // Wrap around
        pdm_q[i] <= acc_sum[i][ACC_W];      // Overflow marks a pulse
      end
    end
  end

  assign pdm_o = pdm_q;

endmodule

`default_nettype wire

// File: logic/hk_regs.sv
// Housekeeping registers
`timescale 1ns/1ps
`default_nettype none

module hk_regs #(
  parameter int unsigned NUM_PDM = 4                     // Number of PDM settings
)(
  input  logic                               adc_clk,    // ADC clock
  input  logic                               rst_n_i,    // Sync reset, active low
  input  rp_pkg::sys_req_t                   sys_req_i,  // Bus request
  output rp_pkg::sys_rsp_t                   sys_rsp_o,  // Bus response
  output logic                               loop_en_o,  // Digital loopback
  output logic             [8-1:0]           led_o,      // LED value
  output rp_pkg::pdm_cfg_t [NUM_PDM-1:0]     pdm_cfg_o   // PDM settings
);

  import rp_pkg::*;

  localparam int unsigned REG_STRIDE = 4;  // Byte spacing of registers

  // Decode
  logic                   strobe;
  logic                   hit_loop;
  logic                   hit_led;
  logic [NUM_PDM-1:0]     hit_pdm;
  logic                   mapped;
  sys_data_t              rdata_d;

  // Registers
  logic                   loop_q;
  logic [8-1:0]           led_q;
  pdm_cfg_t [NUM_PDM-1:0] pdm_q;
  logic                   ack_q;
  logic                   err_q;
  sys_data_t              rdata_q;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign strobe   = sys_req_i.wen | sys_req_i.ren;
  assign hit_loop = (sys_req_i.addr == REG_LOOP);
  assign hit_led  = (sys_req_i.addr == REG_LED);

  always_comb
  begin
    for (int i = 0; i < NUM_PDM; i++)
      hit_pdm[i] = (sys_req_i.addr == REG_PDM0 + sys_addr_t'(REG_STRIDE * i));
  end

  assign mapped = hit_loop | hit_led | (|hit_pdm);

  // Read mux, unmapped reads as zero
  always_comb
  begin
    rdata_d = '0;
    if (hit_loop)
      rdata_d = sys_data_t'(loop_q);
    if (hit_led)
      rdata_d = sys_data_t'(led_q);
    for (int i = 0; i < NUM_PDM; i++)
      if (hit_pdm[i])
        rdata_d = sys_data_t'(pdm_q[i]);
  end

  //////////////////////////////
  // Register writes
  //////////////////////////////

  // Updated on the same edge that raises ack
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
      pdm_q  <= '0;
    end
    else if (sys_req_i.wen)
    begin
      if (hit_loop)
        loop_q <= sys_req_i.wdata[0];
      if (hit_led)
        led_q <= sys_req_i.wdata[8-1:0];
      for (int i = 0; i < NUM_PDM; i++)
        if (hit_pdm[i])
          pdm_q[i] <= sys_req_i.wdata[PDM_DW-1:0];
    end
  end

  //////////////////////////////
  // Bus response
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= strobe;                     // Fixed one cycle answer
      err_q <= strobe & ~mapped;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_q <= sys_req_i.ren ? rdata_d : '0;
  end

  assign sys_rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};
  assign loop_en_o = loop_q;
  assign led_o     = led_q;
  assign pdm_cfg_o = pdm_q;

endmodule

`default_nettype wire

// File: logic/rp_analog_top.sv
// Analog path top level
`timescale 1ns/1ps
`default_nettype none

module rp_analog_top #(
  parameter int unsigned NUM_CH  = 2,                    // ADC and DAC channels
  parameter int unsigned NUM_PDM = 4                     // Auxiliary PDM outputs
)(
  input  logic                                adc_clk,     // ADC clock
  input  logic                                rst_n_i,     // Sync reset, active low
  // ADC
  input  rp_pkg::adc_raw_t    [NUM_CH-1:0]    adc_dat_i,   // Raw converter words
  output rp_pkg::adc_sample_t [NUM_CH-1:0]    adc_dat_o,   // Converted samples
  // Generator and controller
  input  rp_pkg::dac_sample_t [NUM_CH-1:0]    asg_dat_i,
  input  rp_pkg::dac_sample_t [NUM_CH-1:0]    pid_dat_i,
  // DAC
  output rp_pkg::dac_code_t   [NUM_CH-1:0]    dac_dat_o,   // Pin codes
  output logic                                dac_rst_o,   // Active high
  // Housekeeping
  output logic                [NUM_PDM-1:0]   pdm_o,
  output logic                [8-1:0]         led_o,
  // System bus
  input  rp_pkg::sys_req_t                    sys_req_i,
  output rp_pkg::sys_rsp_t                    sys_rsp_o
);

  import rp_pkg::*;

  logic                     digital_loop;  // Loopback from housekeeping
  dac_sample_t [NUM_CH-1:0] dac_sat;       // Saturated DAC samples
  pdm_cfg_t [NUM_PDM-1:0]   pdm_cfg;       // PDM duty settings

  //////////////////////////////
  // ADC front end
  //////////////////////////////

  adc_frontend #(
    .NUM_CH     (NUM_CH)
  ) i_adc_frontend (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .adc_dat_i  (adc_dat_i),
    .loop_en_i  (digital_loop),
    .dac_loop_i (dac_sat),
    .adc_dat_o  (adc_dat_o)
  );

  //////////////////////////////
  // DAC back end
  //////////////////////////////

  dac_backend #(
    .NUM_CH    (NUM_CH)
  ) i_dac_backend (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .asg_dat_i (asg_dat_i),
    .pid_dat_i (pid_dat_i),
    .dac_sat_o (dac_sat),     // Also feeds loopback
    .dac_dat_o (dac_dat_o),
    .dac_rst_o (dac_rst_o)
  );

  //////////////////////////////
  // PDM and housekeeping
  //////////////////////////////

  pdm_gen #(
    .NUM_PDM (NUM_PDM)
  ) i_pdm_gen (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .cfg_i   (pdm_cfg),
    .pdm_o   (pdm_o)
  );

  hk_regs #(
    .NUM_PDM   (NUM_PDM)
  ) i_hk_regs (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .loop_en_o (digital_loop),
    .led_o     (led_o),
    .pdm_cfg_o (pdm_cfg)
  );

endmodule

`default_nettype wire

// File: dv/rp_analog_top_sva.sv
// Bus and DAC reset assertions
`timescale 1ns/1ps
`default_nettype none

module rp_analog_top_sva #(
  parameter int unsigned NUM_CH = 2
)(
  input  logic                              adc_clk,
  input  logic                              rst_n_i,
  input  rp_pkg::sys_req_t                  sys_req_i,
  input  rp_pkg::sys_rsp_t                  sys_rsp_i,   // Top level bus response
  input  rp_pkg::dac_code_t [NUM_CH-1:0]    dac_dat_i,   // Top level DAC pins
  input  logic                              dac_rst_i
);

  import rp_pkg::*;

  logic strobe;

  assign strobe = sys_req_i.wen | sys_req_i.ren;

  // Every strobe answered on the next cycle
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    strobe |=> sys_rsp_i.ack)
    else $error("ack missing one cycle after strobe");

  // No ack without a strobe before it
  ack_one_cycle: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_rsp_i.ack |-> $past(strobe))
    else $error("ack without preceding strobe");

  err_with_ack: assert property (@(posedge adc_clk) sys_rsp_i.err |-> sys_rsp_i.ack)
    else $error("err raised without ack");

  dac_quiet_in_reset: assert property (@(posedge adc_clk) dac_rst_i |-> (dac_dat_i == '0))
    else $error("DAC data not zero during DAC reset");

endmodule

bind rp_analog_top rp_analog_top_sva #(
  .NUM_CH    (NUM_CH)
) i_rp_analog_top_sva (
  .adc_clk   (adc_clk),
  .rst_n_i   (rst_n_i),
  .sys_req_i (sys_req_i),
  .sys_rsp_i (sys_rsp_o),
  .dac_dat_i (dac_dat_o),
  .dac_rst_i (dac_rst_o)
);

`default_nettype wire

// File: dv/tb_rp_analog_top.sv
// Analog path testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rp_analog_top;

  import rp_pkg::*;

  localparam int NUM_CH     = 2;
  localparam int NUM_PDM    = 4;
  localparam int CLK_PERIOD = 8;     // ns
  localparam int RESET_CYC  = 4;
  localparam int NUM_VEC    = 8;     // Table rows
  localparam int NUM_RAND   = 32;    // Extra random rows
  // Table runs up to three times, plus random rows, bus traffic and one PDM window
  localparam int TIMEOUT_CYC = 2 * (RESET_CYC + 3 * NUM_VEC + NUM_RAND + int'(PDM_RNG) + 64);

  // One stimulus row for both channels
  typedef struct packed {
    adc_raw_t    raw0;
    adc_raw_t    raw1;
    dac_sample_t asg0;
    dac_sample_t pid0;
    dac_sample_t asg1;
    dac_sample_t pid1;
  } vec_t;

  logic                     adc_clk;
  logic                     rst_n_i;
  adc_raw_t    [NUM_CH-1:0] adc_dat_i;
  dac_sample_t [NUM_CH-1:0] asg_dat_i;
  dac_sample_t [NUM_CH-1:0] pid_dat_i;
  adc_sample_t [NUM_CH-1:0] adc_dat_o;
  dac_code_t   [NUM_CH-1:0] dac_dat_o;
  logic                     dac_rst_o;
  logic       [NUM_PDM-1:0] pdm_o;
  logic               [7:0] led_o;
  sys_req_t                 sys_req_i;
  sys_rsp_t                 sys_rsp_o;

  int          err_cnt   = 0;
  logic [31:0] rng_state = 32'd83;   // xorshift seed

  // Registered outputs expected from the previous row
  logic [15:0] prev_adc [NUM_CH];
  logic [13:0] prev_dac [NUM_CH];

  // raw0 raw1 asg0 pid0 asg1 pid1, rows 3 4 6 8 hit saturation
  vec_t stim_tab [NUM_VEC] = '{
    '{16'h0000, 16'hFFFF, 14'h0000, 14'h0000, 14'h0001, 14'h3FFF},
    '{16'h7FFF, 16'h8000, 14'h0064, 14'h00C8, 14'h3F9C, 14'h3F38},
    '{16'h1234, 16'hABCD, 14'h1FFF, 14'h0001, 14'h2000, 14'h3FFF},
    '{16'h4000, 16'hC000, 14'h1FFF, 14'h1FFF, 14'h2000, 14'h2000},
    '{16'h0001, 16'hFFFE, 14'h1000, 14'h0FFF, 14'h2000, 14'h1FFF},
    '{16'h8001, 16'h7FFE, 14'h1000, 14'h1000, 14'h3000, 14'h3000},
    '{16'h5A5A, 16'hA5A5, 14'h0ABC, 14'h3123, 14'h0000, 14'h2000},
    '{16'hFFFF, 16'h0000, 14'h1FFE, 14'h0002, 14'h2001, 14'h3FFE}
  };

  rp_analog_top #(
    .NUM_CH    (NUM_CH),
    .NUM_PDM   (NUM_PDM)
  ) i_rp_analog_top (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .adc_dat_i (adc_dat_i),
    .adc_dat_o (adc_dat_o),
    .asg_dat_i (asg_dat_i),
    .pid_dat_i (pid_dat_i),
    .dac_dat_o (dac_dat_o),
    .dac_rst_o (dac_rst_o),
    .pdm_o     (pdm_o),
    .led_o     (led_o),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [15:0] adc_expect(input logic [15:0] raw);
    return raw ^ 16'h7FFF;                 // Magnitude bits flipped
  endfunction

  function automatic logic [13:0] sat_expect(input int a, input int b);
    int s;
    s = a + b;
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s[13:0];
  endfunction

  function automatic logic [13:0] code_expect(input logic [13:0] sat);
    return sat ^ 14'h1FFF;                 // Sign bit stays
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "Stopped on first mismatch");
    end
  endtask

  // All driving happens 1 ns after the edge
  task automatic next_cycle();
    @(posedge adc_clk);
    #1;
  endtask

  task automatic bus_write(input sys_addr_t addr, input sys_data_t data, input logic exp_err);
    sys_req_i = '{addr: addr, wdata: data, wen: 1'b1, ren: 1'b0};
    next_cycle();
    check("write ack", 32'(sys_rsp_o.ack), 32'd1);
    check("write err", 32'(sys_rsp_o.err), 32'(exp_err));
    sys_req_i = '0;
  endtask

  task automatic bus_read(input sys_addr_t addr, input sys_data_t exp_data, input logic exp_err);
    sys_req_i = '{addr: addr, wdata: '0, wen: 1'b0, ren: 1'b1};
    next_cycle();
    check("read ack", 32'(sys_rsp_o.ack), 32'd1);
    check("read err", 32'(sys_rsp_o.err), 32'(exp_err));
    check($sformatf("rdata @%0h", addr), sys_rsp_o.rdata, exp_data);
    sys_req_i = '0;
  endtask

  task automatic draw_vector(output vec_t v);
    logic [31:0] r [3];
    for (int i = 0; i < 3; i++)
    begin
      rng_state = xorshift32(rng_state);
      r[i] = rng_state;
    end
    v = '{r[0][15:0], r[0][31:16], r[1][13:0], r[1][29:16], r[2][13:0], r[2][29:16]};
  endtask

  // Before the edge loopback is live and the registers still hold the last row
  task automatic apply_vector(input vec_t v, input logic loop_on);
    adc_raw_t    raw [NUM_CH];
    dac_sample_t asg [NUM_CH];
    dac_sample_t pid [NUM_CH];
    logic [13:0] sat;
    raw = '{v.raw0, v.raw1};
    asg = '{v.asg0, v.asg1};
    pid = '{v.pid0, v.pid1};
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      adc_dat_i[ch] = raw[ch];
      asg_dat_i[ch] = asg[ch];
      pid_dat_i[ch] = pid[ch];
    end
    #1;
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      sat = sat_expect(int'($signed(asg[ch])), int'($signed(pid[ch])));
      if (loop_on)
        check($sformatf("loopback ch%0d", ch), 32'($unsigned(adc_dat_o[ch])), 32'({2'b00, sat}));
      else
        check($sformatf("adc hold ch%0d", ch), 32'($unsigned(adc_dat_o[ch])), 32'(prev_adc[ch]));
      check($sformatf("dac hold ch%0d", ch), 32'(dac_dat_o[ch]), 32'(prev_dac[ch]));
    end
    next_cycle();
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      sat = sat_expect(int'($signed(asg[ch])), int'($signed(pid[ch])));
      if (!loop_on)
        check($sformatf("adc ch%0d", ch), 32'($unsigned(adc_dat_o[ch])), 32'(adc_expect(raw[ch])));
      check($sformatf("dac ch%0d", ch), 32'(dac_dat_o[ch]), 32'(code_expect(sat)));
      prev_adc[ch] = adc_expect(raw[ch]);
      prev_dac[ch] = code_expect(sat);
    end
  endtask

  task automatic run_pdm_test();
    pdm_cfg_t set [NUM_PDM];
    int       cnt [NUM_PDM];
    set = '{8'd0, 8'd1, 8'd128, 8'd255};
    for (int i = 0; i < NUM_PDM; i++)
      bus_write(REG_PDM0 + sys_addr_t'(4 * i), 32'(set[i]), 1'b0);
    for (int i = 0; i < NUM_PDM; i++)
    begin
      bus_read(REG_PDM0 + sys_addr_t'(4 * i), 32'(set[i]), 1'b0);
      cnt[i] = 0;
    end
    repeat (2) next_cycle();               // Carry register settles
    repeat (int'(PDM_RNG))
    begin
      next_cycle();
      for (int i = 0; i < NUM_PDM; i++)
        cnt[i] += int'(pdm_o[i]);
    end
    for (int i = 0; i < NUM_PDM; i++)
      check($sformatf("pdm%0d high count", i), 32'(cnt[i]), 32'(set[i]));
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    vec_t v;
    rst_n_i   = 1'b0;
    adc_dat_i = '0;
    asg_dat_i = '0;
    pid_dat_i = '0;
    sys_req_i = '0;
    repeat (RESET_CYC) @(posedge adc_clk);
    #1;
    rst_n_i = 1'b1;
    check("dac_rst_o at release", 32'(dac_rst_o), 32'd1);
    next_cycle();
    check("dac_rst_o after release", 32'(dac_rst_o), 32'd0);
    check("dac_dat_o after reset", 32'(dac_dat_o), 32'd0);
    check("ack after reset", 32'(sys_rsp_o.ack), 32'd0);
    check("err after reset", 32'(sys_rsp_o.err), 32'd0);
    check("led_o after reset", 32'(led_o), 32'd0);
    check("pdm_o after reset", 32'(pdm_o), 32'd0);

    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      prev_adc[ch] = adc_expect(16'h0000);  // Idle input already registered
      prev_dac[ch] = '0;                    // Still cleared by the DAC reset
    end

    for (int i = 0; i < NUM_VEC; i++)
      apply_vector(stim_tab[i], 1'b0);
    for (int i = 0; i < NUM_RAND; i++)
    begin
      draw_vector(v);
      apply_vector(v, 1'b0);
    end

    // Loopback on, then back to the ADC path
    bus_write(REG_LOOP, 32'd1, 1'b0);
    bus_read(REG_LOOP, 32'd1, 1'b0);
    for (int i = 0; i < NUM_VEC; i++)
      apply_vector(stim_tab[i], 1'b1);
    bus_write(REG_LOOP, 32'hFFFF_FFFE, 1'b0);
    bus_read(REG_LOOP, 32'd0, 1'b0);
    for (int i = 0; i < 2; i++)
      apply_vector(stim_tab[i], 1'b0);

    bus_read(REG_LED, 32'd0, 1'b0);
    bus_write(REG_LED, 32'hFFFF_FF3C, 1'b0);
    check("led_o", 32'(led_o), 32'h3C);
    bus_read(REG_LED, 32'h3C, 1'b0);
    bus_write(REG_LED, 32'h0000_00A5, 1'b0);
    bus_write(20'h00008, 32'h0000_0077, 1'b1);  // Unmapped, must not land
    bus_read(20'h00008, 32'd0, 1'b1);
    bus_read(20'h00020, 32'd0, 1'b1);
    bus_read(REG_LED, 32'hA5, 1'b0);
    check("led_o", 32'(led_o), 32'hA5);

    run_pdm_test();

    if (err_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in %0d cycles", TIMEOUT_CYC);
    $display("sim failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: sources.f
common/rp_pkg.sv
analog/adc_frontend.sv
analog/dac_backend.sv
logic/pdm_gen.sv
logic/hk_regs.sv
logic/rp_analog_top.sv
dv/rp_analog_top_sva.sv
dv/tb_rp_analog_top.sv

// File: run.sh
#!/bin/sh
# Build and run the analog path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_rp_analog_top \
  -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL (pass line not found in $LOG)"
  exit 1
fi
